// File: adderTree/adderTree.sv
`default_nettype none
`timescale 1ns/1ns

`include "pamFir_macros.svh"

module adderTree (
	input logic sys_clk,
	input logic reset,
	input logic sam_clk_en,
	input pamFir_pkg::sample_t products [`FIR_TAPS],
	output pamFir_pkg::sample_t y
);
	import pamFir_pkg::*;

	sample_t foldSum [`FIR_HALF_TAPS];
	sample_t sum31 [31];
	sample_t sum16 [16];
	sample_t sum8 [8];
	sample_t sum4 [4];
	sample_t sum2 [2];
	sample_t sum1 [1];
	sample_t sumOutReg [1];

	// symmetric fold, centre product passes alone
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			for (int i = 0; i < `FIR_HALF_TAPS; i++)
				foldSum[i] <= '0;
		end else if (sam_clk_en) begin
			for (int i = 0; i < `FIR_HALF_TAPS - 1; i++)
				foldSum[i] <= products[i] + products[`FIR_TAPS-1-i];
			foldSum[`FIR_HALF_TAPS-1] <= products[`FIR_HALF_TAPS-1];
		end
	end

	treeLevel #(.IN_COUNT(`FIR_HALF_TAPS)) level1 (
		.sys_clk, .reset, .sam_clk_en, .sumIn(foldSum), .sumOut(sum31)
	);
	treeLevel #(.IN_COUNT(31)) level2 (
		.sys_clk, .reset, .sam_clk_en, .sumIn(sum31), .sumOut(sum16)
	);
	treeLevel #(.IN_COUNT(16)) level3 (
		.sys_clk, .reset, .sam_clk_en, .sumIn(sum16), .sumOut(sum8)
	);
	treeLevel #(.IN_COUNT(8)) level4 (
		.sys_clk, .reset, .sam_clk_en, .sumIn(sum8), .sumOut(sum4)
	);
	treeLevel #(.IN_COUNT(4)) level5 (
		.sys_clk, .reset, .sam_clk_en, .sumIn(sum4), .sumOut(sum2)
	);
	treeLevel #(.IN_COUNT(2)) level6 (
		.sys_clk, .reset, .sam_clk_en, .sumIn(sum2), .sumOut(sum1)
	);

	// single input level acts as the output register
	treeLevel #(.IN_COUNT(1)) outputStage (
		.sys_clk, .reset, .sam_clk_en, .sumIn(sum1), .sumOut(sumOutReg)
	);

	assign y = sumOutReg[0];

endmodule

`default_nettype wire

// File: adderTree/treeLevel.sv
`default_nettype none
`timescale 1ns/1ns

module treeLevel #(
	parameter int IN_COUNT = 2,
	localparam int OUT_COUNT = (IN_COUNT + 1) / 2
) (
	input logic sys_clk,
	input logic reset,
	input logic sam_clk_en,
	input pamFir_pkg::sample_t sumIn [IN_COUNT],
	output pamFir_pkg::sample_t sumOut [OUT_COUNT]
);

	// pairwise adds wrap at the word width
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			for (int j = 0; j < OUT_COUNT; j++)
				sumOut[j] <= '0;
		end else if (sam_clk_en) begin
			for (int j = 0; j < IN_COUNT / 2; j++)
				sumOut[j] <= sumIn[2*j] + sumIn[2*j+1];
			// odd leftover rides through unchanged
			if (IN_COUNT % 2 == 1)
				sumOut[OUT_COUNT-1] <= sumIn[IN_COUNT-1];
		end
	end

endmodule

`default_nettype wire

// File: common/pamFir_macros.svh
`ifndef PAMFIR_MACROS_SVH
`define PAMFIR_MACROS_SVH

// sample, product and sum width
`define FIR_WIDTH 18

// filter length, and unique taps counting the centre
`define FIR_TAPS 121
`define FIR_HALF_TAPS 61

// PAM symbol amplitudes, negative levels are the negations
`define LEVEL_OUTER 98303
`define LEVEL_INNER 32768

// a sample matches a level strictly inside this distance
`define LEVEL_TOL 2

// strobed register stages from tap 0 to y
`define PIPE_STAGES 8

`endif

// File: common/pamFir_pkg.sv
`default_nettype none

`include "pamFir_macros.svh"

package pamFir_pkg;

	// samples, tap products and partial sums all share one word
	typedef logic signed [`FIR_WIDTH-1:0] sample_t;

	// level detected at a single tap
	typedef enum logic [2:0] {
		levelNeg3,
		levelNeg1,
		levelPos1,
		levelPos3,
		levelNone
	} symbolLevel_t;

endpackage

`default_nettype wire

// File: hdl/firTop.sv
`default_nettype none
`timescale 1ns/1ns

`include "pamFir_macros.svh"

module firTop (
	input logic sys_clk,
	input logic reset,
	input logic sam_clk_en,
	input pamFir_pkg::sample_t x_in,
	output pamFir_pkg::sample_t y
);
	import pamFir_pkg::*;

	sample_t taps [`FIR_TAPS];
	sample_t products [`FIR_TAPS];

	sampleDelayLine delayLine (
		.sys_clk,
		.reset,
		.sam_clk_en,
		.x_in,
		.taps(taps)
	);

	// no multipliers, products come straight from the table
	tapProductBank productBank (
		.taps(taps),
		.products(products)
	);

	adderTree sumTree (
		.sys_clk,
		.reset,
		.sam_clk_en,
		.products(products),
		.y(y)
	);

endmodule

`default_nettype wire

// File: hdl/sampleDelayLine.sv
`default_nettype none
`timescale 1ns/1ns

`include "pamFir_macros.svh"

module sampleDelayLine (
	input logic sys_clk,
	input logic reset,
	input logic sam_clk_en,
	input pamFir_pkg::sample_t x_in,
	output pamFir_pkg::sample_t taps [`FIR_TAPS]
);

	// newest sample in tap 0, oldest in the last tap
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			for (int i = 0; i < `FIR_TAPS; i++)
				taps[i] <= '0;
		end else if (sam_clk_en) begin
			taps[0] <= x_in;
			for (int i = 1; i < `FIR_TAPS; i++)
				taps[i] <= taps[i-1];
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# compile and run the FIR testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f vlog.f --top-module firTop_tb \
	-Mdir "$BUILD_DIR" -o firTop_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

"./$BUILD_DIR/firTop_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
	exit 1
fi

exit 0

// File: tapProducts/tapCoefficientRom.sv
`default_nettype none
`timescale 1ns/1ns

`include "pamFir_macros.svh"

module tapCoefficientRom (
	output pamFir_pkg::sample_t outerProduct [`FIR_HALF_TAPS],
	output pamFir_pkg::sample_t innerProduct [`FIR_HALF_TAPS]
);
	import pamFir_pkg::*;

	// tap times +98303, entry 0 is the outermost tap, entry 60 the centre
	localparam sample_t OUTER_TABLE [`FIR_HALF_TAPS] = '{
		-18'sd18, 18'sd227, 18'sd271, 18'sd270, 18'sd135, -18'sd100,
		-18'sd319, -18'sd378, -18'sd199, 18'sd156, 18'sd494, 18'sd587,
		18'sd316, -18'sd219, -18'sd725, -18'sd862, -18'sd469, 18'sd302,
		18'sd1020, 18'sd1209, 18'sd653, -18'sd417, -18'sd1394, -18'sd1634,
		-18'sd864, 18'sd577, 18'sd1864, 18'sd2147, 18'sd1096, -18'sd806,
		-18'sd2458, -18'sd2765, -18'sd1341, 18'sd1136, 18'sd3219, 18'sd3514,
		18'sd1587, -18'sd1623, -18'sd4223, -18'sd4450, -18'sd1824, 18'sd2361,
		18'sd5616, 18'sd5687, 18'sd2038, -18'sd3538, -18'sd7711, -18'sd7492,
		-18'sd2219, 18'sd5610, 18'sd11328, 18'sd10630, 18'sd2357, -18'sd10051,
		-18'sd19489, -18'sd18342, -18'sd2443, 18'sd26193, 18'sd59391, 18'sd85862,
		18'sd95946
	};

	// same taps times +32768
	localparam sample_t INNER_TABLE [`FIR_HALF_TAPS] = '{
		-18'sd6, 18'sd76, 18'sd90, 18'sd90, 18'sd45, -18'sd33,
		-18'sd106, -18'sd126, -18'sd66, 18'sd52, 18'sd165, 18'sd196,
		18'sd105, -18'sd73, -18'sd242, -18'sd287, -18'sd156, 18'sd101,
		18'sd340, 18'sd403, 18'sd218, -18'sd139, -18'sd465, -18'sd545,
		-18'sd288, 18'sd192, 18'sd621, 18'sd716, 18'sd365, -18'sd269,
		-18'sd819, -18'sd922, -18'sd447, 18'sd379, 18'sd1073, 18'sd1171,
		18'sd529, -18'sd541, -18'sd1408, -18'sd1483, -18'sd608, 18'sd787,
		18'sd1872, 18'sd1896, 18'sd679, -18'sd1179, -18'sd2570, -18'sd2497,
		-18'sd740, 18'sd1870, 18'sd3776, 18'sd3543, 18'sd786, -18'sd3350,
		-18'sd6496, -18'sd6114, -18'sd814, 18'sd8731, 18'sd19797, 18'sd28621,
		18'sd31982
	};

	assign outerProduct = OUTER_TABLE;
	assign innerProduct = INNER_TABLE;

endmodule

`default_nettype wire

// File: tapProducts/tapProductBank.sv
`default_nettype none
`timescale 1ns/1ns

`include "pamFir_macros.svh"

module tapProductBank (
	input pamFir_pkg::sample_t taps [`FIR_TAPS],
	output pamFir_pkg::sample_t products [`FIR_TAPS]
);
	import pamFir_pkg::*;

	sample_t outerProduct [`FIR_HALF_TAPS];
	sample_t innerProduct [`FIR_HALF_TAPS];

	// strict window around one level
	function automatic logic nearLevel(input sample_t v, input sample_t target);
		sample_t lo;
		sample_t hi;
		lo = target - sample_t'(`LEVEL_TOL);
		hi = target + sample_t'(`LEVEL_TOL);
		return (v > lo) && (v < hi);
	endfunction

	function automatic symbolLevel_t classify(input sample_t v);
		if (nearLevel(v, sample_t'(`LEVEL_OUTER)))
			return levelPos3;
		if (nearLevel(v, sample_t'(`LEVEL_INNER)))
			return levelPos1;
		if (nearLevel(v, sample_t'(-`LEVEL_INNER)))
			return levelNeg1;
		if (nearLevel(v, sample_t'(-`LEVEL_OUTER)))
			return levelNeg3;
		return levelNone;
	endfunction

	function automatic sample_t selectProduct(input symbolLevel_t level,
			input sample_t outer, input sample_t inner);
		case (level)
			levelPos3: return outer;
			levelPos1: return inner;
			levelNeg1: return -inner;
			levelNeg3: return -outer;
			default: return '0;
		endcase
	endfunction

	tapCoefficientRom coefRom (
		.outerProduct(outerProduct),
		.innerProduct(innerProduct)
	);

	for (genvar i = 0; i < `FIR_TAPS; i++) begin : genTap
		// mirror taps read the same entry
		localparam int ENTRY = (i < `FIR_HALF_TAPS) ? i : `FIR_TAPS - 1 - i;

		symbolLevel_t level;

		assign level = classify(taps[i]);
		assign products[i] = selectProduct(level, outerProduct[ENTRY], innerProduct[ENTRY]);
	end

endmodule

`default_nettype wire

// File: test/firTop_assert.sv
`default_nettype none
`timescale 1ns/1ns

`include "pamFir_macros.svh"

module firTop_assert (
	input logic sys_clk,
	input logic reset,
	input logic sam_clk_en,
	input pamFir_pkg::sample_t y
);

	// strobes since reset, saturating one past the pipeline depth
	int strobeCount;

	always_ff @(posedge sys_clk) begin
		if (reset)
			strobeCount <= 0;
		else if (sam_clk_en && strobeCount <= `PIPE_STAGES)
			strobeCount <= strobeCount + 1;
	end

	// output register holds without strobe or reset
	holdWhileIdle: assert property (
		@(posedge sys_clk) (!reset && !sam_clk_en) |=> $stable(y)
	) else $error("y changed on a cycle without a strobe");

	// reset wins over the strobe
	clearedByReset: assert property (
		@(posedge sys_clk) reset |=> (y == '0)
	) else $error("y not zero on the cycle after reset");

	// nothing reaches y before the pipeline has filled
	zeroWhileFilling: assert property (
		@(posedge sys_clk) (!reset && strobeCount <= `PIPE_STAGES) |-> (y == '0)
	) else $error("y nonzero before the pipeline filled after reset");

endmodule

`default_nettype wire

// File: test/firTop_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "pamFir_macros.svh"

module firTop_tb;
	import pamFir_pkg::*;

	localparam int MAX_LINES = 2000;
	localparam int CLEAR_TIMEOUT = 4;
	localparam int WATCHDOG_CYCLES = 5000;

	logic sys_clk;
	logic reset;
	logic sam_clk_en;
	sample_t x_in;
	sample_t y;

	int errorCount;
	int checkCount;
	int testCount;
	int testChecks;
	int testErrors;
	int strobesSinceReset;
	bit testOpen;

	// last captured strobe, compared half a cycle later
	sample_t pendingExpected;
	int pendingLine;
	bit pendingValid;

	firTop DUT (
		.sys_clk,
		.reset,
		.sam_clk_en,
		.x_in,
		.y
	);

	bind firTop firTop_assert assertChecks (
		.sys_clk,
		.reset,
		.sam_clk_en,
		.y
	);

	// 8 ns period
	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	initial begin : watchdog
		for (int c = 0; c < WATCHDOG_CYCLES; c++)
			@(posedge sys_clk);
		$display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	task automatic countError();
		errorCount++;
		if (testOpen)
			testErrors++;
	endtask

	task automatic startTest();
		testCount++;
		testChecks = 0;
		testErrors = 0;
		strobesSinceReset = 0;
		testOpen = 1'b1;
	endtask

	task automatic finishTest();
		$display("Test %0d finished: %0d checks, %0d errors", testCount, testChecks, testErrors);
		testOpen = 1'b0;
	endtask

	task automatic idleCycles(input int count);
		for (int i = 0; i < count; i++)
			@(posedge sys_clk);
	endtask

	task automatic checkOutput(input sample_t expected, input int lineNo);
		checkCount++;
		testChecks++;
		if (y !== expected) begin
			$display("Mismatch at %0t ns: y = %0d, expected %0d (vector line %0d)",
				$time, y, expected, lineNo);
			countError();
		end
		// pipeline still filling
		if (strobesSinceReset <= `PIPE_STAGES && y !== '0) begin
			$display("Mismatch at %0t ns: y = %0d, expected 0 within %0d strobes of reset",
				$time, y, `PIPE_STAGES);
			countError();
		end
	endtask

	// y is read on the falling edge, away from the register update
	task automatic checkPending();
		@(negedge sys_clk);
		if (pendingValid) begin
			checkOutput(pendingExpected, pendingLine);
			pendingValid = 1'b0;
		end
	endtask

	// reset edge arrives with the strobe still high
	task automatic releaseReset();
		int waited;
		@(posedge sys_clk);
		reset <= 1'b0;
		sam_clk_en <= 1'b0;
		@(negedge sys_clk);
		waited = 0;
		while (y !== '0 && waited < CLEAR_TIMEOUT) begin
			@(negedge sys_clk);
			waited++;
		end
		if (y !== '0) begin
			$display("Error: y did not clear within %0d cycles of reset", CLEAR_TIMEOUT);
			countError();
		end
		@(posedge sys_clk);
	endtask

	// gap is the number of idle edges before the capturing edge
	task automatic strobeSample(input sample_t sample, input int gap);
		if (gap == 0) begin
			x_in <= sample;
			sam_clk_en <= 1'b1;
		end else begin
			sam_clk_en <= 1'b0;
		end
		checkPending();
		if (gap > 0) begin
			idleCycles(gap);
			x_in <= sample;
			sam_clk_en <= 1'b1;
		end
		@(posedge sys_clk);
		strobesSinceReset++;
	endtask

	initial begin : stimulus
		int fd;
		string line;
		int n;
		int rstFlag;
		int sampleVal;
		int expectedVal;
		int lineNo;
		int gap;
		reset = 1'b1;
		sam_clk_en = 1'b0;
		x_in = '0;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		testOpen = 1'b0;
		pendingValid = 1'b0;
		void'($urandom(32'h1c73));
		repeat (3) @(posedge sys_clk);
		reset <= 1'b0;
		@(posedge sys_clk);
		fd = $fopen("test/firTop_vectors.txt", "r");
		if (fd == 0) begin
			$display("Error: cannot open test/firTop_vectors.txt");
			errorCount++;
		end else begin
			lineNo = 0;
			while (!$feof(fd) && lineNo < MAX_LINES) begin
				lineNo++;
				if ($fgets(line, fd) == 0)
					break;
				if (line.len() < 2 || line.substr(0, 0) == "#")
					continue;
				n = $sscanf(line, "%d %d %d", rstFlag, sampleVal, expectedVal);
				if (n != 3) begin
					$display("Error: vector line %0d is malformed", lineNo);
					countError();
					continue;
				end
				if (rstFlag != 0) begin
					// reset and strobe go out together on this edge
					reset <= 1'b1;
					sam_clk_en <= 1'b1;
					x_in <= sample_t'(sampleVal);
					checkPending();
					if (testOpen)
						finishTest();
					startTest();
					releaseReset();
				end else if (!testOpen) begin
					$display("Error: vector line %0d comes before any reset line", lineNo);
					errorCount++;
					continue;
				end
				// random idle gap ahead of each strobe
				gap = int'($urandom % 4);
				strobeSample(sample_t'(sampleVal), gap);
				pendingExpected = sample_t'(expectedVal);
				pendingLine = lineNo;
				pendingValid = 1'b1;
			end
			$fclose(fd);
			sam_clk_en <= 1'b0;
			checkPending();
			if (testOpen)
				finishTest();
		end
		if (checkCount == 0) begin
			$display("Error: no vectors were checked");
			errorCount++;
		end
		$display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/firTop_vectors.txt
# columns: reset flag, input sample, expected y after that strobe
# a reset flag of 1 starts a new test with a reset before its strobe
1 98303 0
0 0 0
0 0 0
0 0 0
0 0 0
0 0 0
0 0 0
0 0 0
0 0 -18
0 0 227
0 0 271
0 0 270
0 0 135
0 0 -100
1 98304 0
0 -32768 0
0 32767 0
0 -98302 0
0 0 0
0 0 0
0 0 0
0 0 0
0 0 -18
0 0 233
0 0 189
0 0 274
0 0 -92
0 0 -326
1 1000 0
0 98305 0
0 32766 0
0 -32770 0
0 -98301 0
0 32768 0
0 0 0
0 0 0
0 0 0
0 0 0
0 0 0
0 0 0
0 0 0
0 0 -6
0 0 76
1 -98303 0
0 0 0
0 0 0
0 0 0
0 0 0
0 0 0
0 0 0
0 0 0
0 0 18
0 0 -227

// File: vlog.f
+incdir+common
common/pamFir_pkg.sv
tapProducts/tapCoefficientRom.sv
tapProducts/tapProductBank.sv
hdl/sampleDelayLine.sv
adderTree/treeLevel.sv
adderTree/adderTree.sv
hdl/firTop.sv
test/firTop_assert.sv
test/firTop_tb.sv
